// File: src/display_pkg.sv
/* Raster and video types shared along the pixel pipeline
   Coordinate width, RGB colour, raster position and DVI output word */
package display_pkg;

    localparam int CORDW = 12;  // Screen coordinate width

    // One pixel colour, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Scan position and timing flags, one per pixel clock
    typedef struct packed {
        logic [CORDW-1:0] sx;  // Horizontal position, 0 at left
        logic [CORDW-1:0] sy;  // Vertical position, 0 at top
        logic hsync;           // Active high
        logic vsync;           // Active high
        logic de;              // Inside active area
        logic frame_start;     // Position (0,0)
    } raster_pos_t;

    // Registered word for the DVI encoder
    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
        logic de;
    } dvi_word_t;

endpackage

// File: src/graph_pkg.sv
/* Plot opcodes, configuration struct and register map
   Register offsets, CTRL field layout and AXI response codes */
package graph_pkg;

    // Curve selection
    typedef enum logic [1:0] {
        FUNC_LINE    = 2'd0,  // y = x
        FUNC_SQUARED = 2'd1,  // y = x^2 >> shift
        FUNC_CUBED   = 2'd2,  // y = x^3 >> 2*shift
        FUNC_NONE    = 2'd3   // Draws nothing
    } func_op_t;

    // Full plot configuration as held by the register slave
    typedef struct packed {
        func_op_t          op;
        logic [3:0]        shift;     // Curve scale
        logic              enable;    // Plot on
        display_pkg::rgb_t col_func;
        display_pkg::rgb_t col_axes;
        display_pkg::rgb_t col_bg;
    } plot_cfg_t;

    // Byte offsets
    localparam logic [3:0] REG_CTRL     = 4'h0;
    localparam logic [3:0] REG_COL_FUNC = 4'h4;
    localparam logic [3:0] REG_COL_AXES = 4'h8;
    localparam logic [3:0] REG_COL_BG   = 4'hC;

    // CTRL layout, op sits in bits 1:0
    localparam int CTRL_SHIFT_LSB = 4;  // Shift in bits 7:4
    localparam int CTRL_EN_BIT    = 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/display_timing.sv
/* Display timing generator
   Scan counters with sync, data enable and frame start flags */
`timescale 1ns/1ps

module display_timing #(
    parameter int H_RES  = 1280,
    parameter int V_RES  = 720,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
) (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    output display_pkg::raster_pos_t pos
);

    localparam int CW = display_pkg::CORDW;

    // Horizontal boundaries, active area first
    localparam logic [CW-1:0] H_ACT      = CW'(H_RES);
    localparam logic [CW-1:0] H_SYNC_BEG = CW'(H_RES + H_FP);
    localparam logic [CW-1:0] H_SYNC_END = CW'(H_RES + H_FP + H_SYNC);
    localparam logic [CW-1:0] H_LAST     = CW'(H_RES + H_FP + H_SYNC + H_BP - 1);

    // Vertical boundaries in lines
    localparam logic [CW-1:0] V_ACT      = CW'(V_RES);
    localparam logic [CW-1:0] V_SYNC_BEG = CW'(V_RES + V_FP);
    localparam logic [CW-1:0] V_SYNC_END = CW'(V_RES + V_FP + V_SYNC);
    localparam logic [CW-1:0] V_LAST     = CW'(V_RES + V_FP + V_SYNC + V_BP - 1);

    logic [CW-1:0] sx;
    logic [CW-1:0] sy;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // End of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // Flags decoded straight from the counters
    always_comb begin
        pos.sx          = sx;
        pos.sy          = sy;
        pos.hsync       = (sx >= H_SYNC_BEG) && (sx < H_SYNC_END);
        pos.vsync       = (sy >= V_SYNC_BEG) && (sy < V_SYNC_END);
        pos.de          = (sx < H_ACT) && (sy < V_ACT);
        pos.frame_start = (sx == '0) && (sy == '0);  // First active pixel
    end

endmodule

// File: src/graph_regs.sv
/* AXI4-Lite register slave for the plot configuration
   CTRL and three colour registers, byte strobes, OKAY/SLVERR responses */
`timescale 1ns/1ps

module graph_regs (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic [3:0]           s_axi_awaddr,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  logic [31:0]          s_axi_wdata,
    input  logic [3:0]           s_axi_wstrb,
    input  logic                 s_axi_wvalid,
    output logic                 s_axi_wready,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    input  logic [3:0]           s_axi_araddr,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output logic [31:0]          s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,
    output graph_pkg::plot_cfg_t cfg
);

    typedef enum logic {RESP_IDLE, RESP_HOLD} resp_state_t;

    resp_state_t wr_state;
    resp_state_t rd_state;
    logic        wr_fire;  // AW and W taken together
    logic        rd_fire;
    logic [31:0] wr_new;   // Register after strobe merge
    logic [31:0] rd_word;

    // Register contents as the bus sees them, zero when unmapped
    function automatic logic [31:0] reg_word(input logic [3:0] addr,
                                             input graph_pkg::plot_cfg_t c);
        logic [31:0] w;
        w = '0;
        case (addr)
            graph_pkg::REG_CTRL: begin
                w[1:0]                              = c.op;
                w[graph_pkg::CTRL_SHIFT_LSB +: 4]   = c.shift;
                w[graph_pkg::CTRL_EN_BIT]           = c.enable;
            end
            graph_pkg::REG_COL_FUNC: w[23:0] = c.col_func;
            graph_pkg::REG_COL_AXES: w[23:0] = c.col_axes;
            graph_pkg::REG_COL_BG:   w[23:0] = c.col_bg;
            default:                 w = '0;
        endcase
        return w;
    endfunction

    function automatic logic is_mapped(input logic [3:0] addr);
        return addr inside {graph_pkg::REG_CTRL, graph_pkg::REG_COL_FUNC,
                            graph_pkg::REG_COL_AXES, graph_pkg::REG_COL_BG};
    endfunction

    assign wr_fire = s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready;
    assign rd_fire = s_axi_arvalid && s_axi_arready;

    always_comb begin
        wr_new = reg_word(s_axi_awaddr, cfg);
        for (int i = 0; i < 4; i++) begin
            if (s_axi_wstrb[i])
                wr_new[8*i +: 8] = s_axi_wdata[8*i +: 8];  // Take strobed byte
        end
        rd_word = reg_word(s_axi_araddr, cfg);
    end

    // Write channel and register update
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            wr_state      <= RESP_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            cfg.op        <= graph_pkg::FUNC_NONE;
            cfg.shift     <= '0;
            cfg.enable    <= 1'b0;
            cfg.col_func  <= '0;
            cfg.col_axes  <= '0;
            cfg.col_bg    <= '0;
        end else begin
            case (wr_state)
                RESP_IDLE: begin
                    if (wr_fire) begin
                        s_axi_awready <= 1'b0;
                        s_axi_wready  <= 1'b0;
                        wr_state      <= RESP_HOLD;
                        case (s_axi_awaddr)
                            graph_pkg::REG_CTRL: begin
                                cfg.op     <= graph_pkg::func_op_t'(wr_new[1:0]);
                                cfg.shift  <= wr_new[graph_pkg::CTRL_SHIFT_LSB +: 4];
                                cfg.enable <= wr_new[graph_pkg::CTRL_EN_BIT];
                            end
                            graph_pkg::REG_COL_FUNC: cfg.col_func <= wr_new[23:0];
                            graph_pkg::REG_COL_AXES: cfg.col_axes <= wr_new[23:0];
                            graph_pkg::REG_COL_BG:   cfg.col_bg   <= wr_new[23:0];
                            default: ;  // Unmapped, nothing changes
                        endcase
                    end else if (s_axi_awvalid && s_axi_wvalid) begin
                        s_axi_awready <= 1'b1;  // Both halves present
                        s_axi_wready  <= 1'b1;
                    end
                end
                RESP_HOLD: if (s_axi_bready) wr_state <= RESP_IDLE;
                default:   wr_state <= RESP_IDLE;
            endcase
        end
    end

    // Read channel
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            rd_state      <= RESP_IDLE;
            s_axi_arready <= 1'b0;
        end else begin
            case (rd_state)
                RESP_IDLE: begin
                    if (rd_fire) begin
                        s_axi_arready <= 1'b0;
                        rd_state      <= RESP_HOLD;
                    end else if (s_axi_arvalid) begin
                        s_axi_arready <= 1'b1;
                    end
                end
                RESP_HOLD: if (s_axi_rready) rd_state <= RESP_IDLE;
                default:   rd_state <= RESP_IDLE;
            endcase
        end
    end

    // Response payload, captured at accept
    always_ff @(posedge clk_pix) begin
        if (wr_fire)
            s_axi_bresp <= is_mapped(s_axi_awaddr) ? graph_pkg::RESP_OKAY
                                                   : graph_pkg::RESP_SLVERR;
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= is_mapped(s_axi_araddr) ? graph_pkg::RESP_OKAY
                                                   : graph_pkg::RESP_SLVERR;
        end
    end

    assign s_axi_bvalid = (wr_state == RESP_HOLD);
    assign s_axi_rvalid = (rd_state == RESP_HOLD);

endmodule

// File: src/func_plot.sv
/* Pipelined curve evaluator
   Three stages: x squared, x cubed, compare against y per opcode */
`timescale 1ns/1ps

module func_plot (
    input  logic                                clk_pix,
    input  logic signed [display_pkg::CORDW-1:0] x,
    input  logic signed [display_pkg::CORDW-1:0] y,
    input  graph_pkg::func_op_t                 op,
    input  logic [3:0]                          shift,
    output logic                                on_curve
);

    localparam int CW = display_pkg::CORDW;

    // Operands carried alongside the products
    typedef struct packed {
        logic signed [CW-1:0] x;
        logic signed [CW-1:0] y;
        graph_pkg::func_op_t  op;
        logic [3:0]           shift;
    } carry_t;

    carry_t                 c1;   // Stage 1
    carry_t                 c2;   // Stage 2
    logic signed [2*CW-1:0] sq1;  // x^2
    logic signed [2*CW-1:0] sq2;
    logic signed [3*CW-1:0] cb2;  // x^3
    logic                   hit;

    // Stage 1, square
    always_ff @(posedge clk_pix) begin
        c1.x     <= x;
        c1.y     <= y;
        c1.op    <= op;
        c1.shift <= shift;
        sq1      <= x * x;
    end

    // Stage 2, cube from the square
    always_ff @(posedge clk_pix) begin
        c2  <= c1;
        sq2 <= sq1;
        cb2 <= sq1 * $signed(c1.x);
    end

    // Stage 3 compare, arithmetic shifts keep the sign of odd powers
    always_comb begin
        case (c2.op)
            graph_pkg::FUNC_LINE:    hit = ($signed(c2.y) == $signed(c2.x));
            graph_pkg::FUNC_SQUARED: hit = ($signed(c2.y) == (sq2 >>> c2.shift));
            graph_pkg::FUNC_CUBED:   hit = ($signed(c2.y) == (cb2 >>> {c2.shift, 1'b0}));
            default:                 hit = 1'b0;  // FUNC_NONE
        endcase
    end

    always_ff @(posedge clk_pix) begin
        on_curve <= hit;
    end

endmodule

// File: src/graph_painter.sv
/* Pixel painter: centring, axis flag, frame-start config latch
   Sync and axis delay to match the plotter, registered colour out */
`timescale 1ns/1ps

module graph_painter #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  logic                                 clk_pix,
    input  logic                                 rst_n,
    input  display_pkg::raster_pos_t             pos,
    input  graph_pkg::plot_cfg_t                 cfg,
    output logic signed [display_pkg::CORDW-1:0] x,
    output logic signed [display_pkg::CORDW-1:0] y,
    output graph_pkg::func_op_t                  op,
    output logic [3:0]                           shift,
    input  logic                                 on_curve,
    output display_pkg::dvi_word_t               video
);

    localparam int CW       = display_pkg::CORDW;
    localparam int FUNC_LAT = 3;  // func_plot depth
    localparam logic [CW-1:0] X_OFFS = CW'(H_RES / 2);
    localparam logic [CW-1:0] Y_OFFS = CW'(V_RES / 2 - 1);

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        logic axis;
    } side_t;

    graph_pkg::plot_cfg_t cfg_act;  // Copy used for the current frame
    side_t                side_d [FUNC_LAT+1];

    // Take new settings only at (0,0), so no frame tears
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            cfg_act.op       <= graph_pkg::FUNC_NONE;
            cfg_act.shift    <= '0;
            cfg_act.enable   <= 1'b0;
            cfg_act.col_func <= '0;
            cfg_act.col_axes <= '0;
            cfg_act.col_bg   <= '0;
        end else if (pos.frame_start) begin
            cfg_act <= cfg;
        end
    end

    // Centre the screen, y grows upwards
    always_ff @(posedge clk_pix) begin
        x <= signed'(pos.sx - X_OFFS);
        y <= signed'(Y_OFFS - pos.sy);
    end

    assign op    = cfg_act.op;     // Meets the pixel entering func_plot
    assign shift = cfg_act.shift;

    // Side flags, one cycle centring plus the plotter depth
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int i = 0; i <= FUNC_LAT; i++)
                side_d[i] <= '0;
        end else begin
            side_d[0].hsync <= pos.hsync;
            side_d[0].vsync <= pos.vsync;
            side_d[0].de    <= pos.de;
            side_d[0].axis  <= (pos.sx == X_OFFS) || (pos.sy == Y_OFFS);
            for (int i = 1; i <= FUNC_LAT; i++)
                side_d[i] <= side_d[i-1];
        end
    end

    // Colours can switch at frame start since the tail is still in blanking
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.hsync <= side_d[FUNC_LAT].hsync;
            video.vsync <= side_d[FUNC_LAT].vsync;
            video.de    <= side_d[FUNC_LAT].de;
            if (!side_d[FUNC_LAT].de)
                video.rgb <= '0;                 // Blanking
            else if (side_d[FUNC_LAT].axis)
                video.rgb <= cfg_act.col_axes;   // Axes on top
            else if (on_curve && cfg_act.enable)
                video.rgb <= cfg_act.col_func;
            else
                video.rgb <= cfg_act.col_bg;
        end
    end

endmodule

// File: src/graph_top.sv
/* Graphing subsystem top level
   Register slave, display timing, curve plotter and painter */
`timescale 1ns/1ps

module graph_top #(
    parameter int H_RES  = 1280,
    parameter int V_RES  = 720,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
) (
    input  logic                   clk_pix,
    input  logic                   rst_n,
    input  logic [3:0]             s_axi_awaddr,
    input  logic                   s_axi_awvalid,
    output logic                   s_axi_awready,
    input  logic [31:0]            s_axi_wdata,
    input  logic [3:0]             s_axi_wstrb,
    input  logic                   s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic [1:0]             s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,
    input  logic [3:0]             s_axi_araddr,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,
    output logic [31:0]            s_axi_rdata,
    output logic [1:0]             s_axi_rresp,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,
    output display_pkg::dvi_word_t video
);

    graph_pkg::plot_cfg_t                 cfg;       // Register view
    display_pkg::raster_pos_t             pos;
    logic signed [display_pkg::CORDW-1:0] x;         // Centred coordinates
    logic signed [display_pkg::CORDW-1:0] y;
    graph_pkg::func_op_t                  op;
    logic [3:0]                           shift;
    logic                                 on_curve;

    graph_regs graph_regs_i (
        .clk_pix, .rst_n,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
        .cfg
    );

    display_timing #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) display_timing_i (
        .clk_pix, .rst_n, .pos
    );

    func_plot func_plot_i (
        .clk_pix, .x, .y, .op, .shift, .on_curve
    );

    graph_painter #(.H_RES(H_RES), .V_RES(V_RES)) graph_painter_i (
        .clk_pix, .rst_n, .pos, .cfg,
        .x, .y, .op, .shift, .on_curve, .video
    );

endmodule

// File: bench/graph_top_tb.sv
/* Directed testbench for graph_top
   AXI4-Lite register driver, raster scoreboard, LFSR and cycle timeout */
`timescale 1ns/1ps

module graph_top_tb;

    localparam int H_RES     = 32;  // Tiny raster
    localparam int V_RES     = 16;
    localparam int H_FP      = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BP      = 3;
    localparam int V_FP      = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BP      = 1;
    localparam int LINE_CYC  = H_RES + H_FP + H_SYNC + H_BP;
    localparam int FRAME_CYC = LINE_CYC * (V_RES + V_FP + V_SYNC + V_BP);
    localparam int N_CHECKS  = 9;   // Frames compared
    localparam int REG_OPS   = 24;  // Bus transactions rounded up
    // Each compared frame may first wait up to a frame
    localparam int TIMEOUT   = (2 * N_CHECKS + 1) * FRAME_CYC + REG_OPS * 12;

    logic                   clk_pix = 1'b0;
    logic                   rst_n;
    logic [3:0]             s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [31:0]            s_axi_wdata;
    logic [3:0]             s_axi_wstrb;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic [1:0]             s_axi_bresp;
    logic                   s_axi_bvalid;
    logic                   s_axi_bready;
    logic [3:0]             s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [31:0]            s_axi_rdata;
    logic [1:0]             s_axi_rresp;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;
    display_pkg::dvi_word_t video;

    logic [31:0]          lfsr = 32'ha239;
    graph_pkg::plot_cfg_t shadow;  // What software has written
    int                   cycles = 0;
    int                   value_errs = 0;
    int                   other_errs = 0;

    graph_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) graph_top_i (.*);

    always #4 clk_pix = ~clk_pix;  // 8 ns period

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic value_error(input string msg);
        value_errs++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic protocol_error(input string msg);
        other_errs++;
        $display("Protocol problem at %0t: %s", $time, msg);
    endtask

    // CTRL word with op in bits 1:0, shift in 7:4 and enable in 8
    function automatic logic [31:0] ctrl_word(input graph_pkg::func_op_t op,
                                              input logic [3:0] shift, input logic en);
        return {23'd0, en, shift, 2'b00, op};
    endfunction

    function automatic logic [31:0] reg_image(input logic [3:0] addr);
        case (addr)
            graph_pkg::REG_CTRL:     return ctrl_word(shadow.op, shadow.shift, shadow.enable);
            graph_pkg::REG_COL_FUNC: return {8'h00, shadow.col_func};
            graph_pkg::REG_COL_AXES: return {8'h00, shadow.col_axes};
            graph_pkg::REG_COL_BG:   return {8'h00, shadow.col_bg};
            default:                 return 32'h0;  // Unmapped
        endcase
    endfunction

    // Expected colour of screen pixel (sx,sy) with the origin at (H_RES/2, V_RES/2-1) and y up
    function automatic display_pkg::rgb_t expect_pixel(input graph_pkg::plot_cfg_t c,
                                                       input int sx, input int sy);
        int   x;
        int   y;
        logic hit;
        x = sx - H_RES / 2;
        y = V_RES / 2 - 1 - sy;
        case (c.op)
            graph_pkg::FUNC_LINE:    hit = (y == x);
            graph_pkg::FUNC_SQUARED: hit = (y == ((x * x) >>> c.shift));
            graph_pkg::FUNC_CUBED:   hit = (y == ((x * x * x) >>> (2 * c.shift)));
            default:                 hit = 1'b0;
        endcase
        if (x == 0 || y == 0)
            return c.col_axes;  // Axes win
        else if (hit && c.enable)
            return c.col_func;
        return c.col_bg;
    endfunction

    // Write with a random bready stall of 0 to 3 cycles
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int hold;
        hold = int'(lfsr_bits(2));
        @(posedge clk_pix);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= 4'hF;
        s_axi_wvalid  <= 1'b1;
        do begin
            @(posedge clk_pix);
        end while (!(s_axi_awready && s_axi_wready));  // Taken at this edge
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        do begin
            @(posedge clk_pix);
        end while (!s_axi_bvalid);
        repeat (hold) begin
            @(posedge clk_pix);
            if (!s_axi_bvalid)
                protocol_error("bvalid dropped while bready was low");
        end
        s_axi_bready <= 1'b1;
        @(posedge clk_pix);
        if (!s_axi_bvalid)
            protocol_error("bvalid gone before bready was seen");
        resp = s_axi_bresp;
        s_axi_bready <= 1'b0;
    endtask

    // Read with a random rready stall
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int hold;
        hold = int'(lfsr_bits(2));
        @(posedge clk_pix);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do begin
            @(posedge clk_pix);
        end while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        do begin
            @(posedge clk_pix);
        end while (!s_axi_rvalid);
        repeat (hold) begin
            @(posedge clk_pix);
            if (!s_axi_rvalid)
                protocol_error("rvalid dropped while rready was low");
        end
        s_axi_rready <= 1'b1;
        @(posedge clk_pix);
        if (!s_axi_rvalid)
            protocol_error("rvalid gone before rready was seen");
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready <= 1'b0;
    endtask

    task automatic verify_register(input logic [3:0] addr);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        if (data !== reg_image(addr) || resp !== graph_pkg::RESP_OKAY)
            value_error($sformatf("read of %h gave %h resp %b, expected %h",
                                  addr, data, resp, reg_image(addr)));
    endtask

    task automatic write_ctrl(input graph_pkg::func_op_t op, input logic [3:0] shift,
                              input logic en);
        logic [1:0] resp;
        axi_write(graph_pkg::REG_CTRL, ctrl_word(op, shift, en), resp);
        if (resp !== graph_pkg::RESP_OKAY)
            value_error($sformatf("CTRL write resp %b", resp));
        shadow.op     = op;
        shadow.shift  = shift;
        shadow.enable = en;
    endtask

    task automatic write_colour(input logic [3:0] addr, input display_pkg::rgb_t col);
        logic [1:0] resp;
        axi_write(addr, {8'h00, col}, resp);
        if (resp !== graph_pkg::RESP_OKAY)
            value_error($sformatf("colour write to %h resp %b", addr, resp));
        case (addr)
            graph_pkg::REG_COL_FUNC: shadow.col_func = col;
            graph_pkg::REG_COL_AXES: shadow.col_axes = col;
            default:                 shadow.col_bg   = col;
        endcase
    endtask

    task automatic wait_vsync(input logic level);
        do begin
            @(negedge clk_pix);
        end while (video.vsync !== level);
    endtask

    // Rebuild sx and sy from de and syncs and compare a whole frame
    task automatic check_frame(input graph_pkg::plot_cfg_t c, input string tag);
        int                sx;
        int                sy;
        int                hs_cnt;
        logic              de_q;
        display_pkg::rgb_t want;
        sx     = 0;
        sy     = 0;
        hs_cnt = 0;
        de_q   = 1'b0;
        wait_vsync(1'b1);
        wait_vsync(1'b0);  // Blanking before the next frame
        while (!video.vsync) begin
            if (video.hsync)
                hs_cnt++;
            if (video.de) begin
                want = expect_pixel(c, sx, sy);
                if (video.rgb !== want)
                    value_error($sformatf("%s pixel (%0d,%0d) is %h, expected %h",
                                          tag, sx, sy, video.rgb, want));
                if (video.hsync)
                    protocol_error($sformatf("%s hsync inside de on line %0d", tag, sy));
                sx++;
            end else begin
                if (video.rgb !== '0)
                    value_error($sformatf("%s blanking colour %h", tag, video.rgb));
                if (de_q) begin  // End of an active line
                    if (sx != H_RES)
                        protocol_error($sformatf("%s line %0d has %0d pixels", tag, sy, sx));
                    sx = 0;
                    sy++;
                end
            end
            de_q = video.de;
            @(negedge clk_pix);
        end
        if (sy != V_RES)
            protocol_error($sformatf("%s frame has %0d lines instead of %0d", tag, sy, V_RES));
        // One hsync pulse per line between the vsync pulses
        if (hs_cnt != (V_RES + V_FP + V_BP) * H_SYNC)
            protocol_error($sformatf("%s frame has %0d hsync cycles instead of %0d",
                                     tag, hs_cnt, (V_RES + V_FP + V_BP) * H_SYNC));
    endtask

    task automatic check_reset_state();
        if (video !== '0)
            value_error($sformatf("video word %h during reset", video));
        if ({s_axi_awready, s_axi_wready, s_axi_arready, s_axi_bvalid, s_axi_rvalid} !== '0)
            value_error("AXI ready or valid outputs high during reset");
        verify_register(graph_pkg::REG_CTRL);  // FUNC_NONE with enable clear
    endtask

    task automatic exercise_registers();
        logic [3:0]  addrs [3];
        logic [31:0] data;
        logic [1:0]  resp;
        addrs = '{graph_pkg::REG_COL_FUNC, graph_pkg::REG_COL_AXES, graph_pkg::REG_COL_BG};
        foreach (addrs[i]) begin
            write_colour(addrs[i], display_pkg::rgb_t'(lfsr_bits(24)));
            verify_register(addrs[i]);
        end
        axi_write(4'h6, 32'hFFFF_FFFF, resp);  // Unmapped offset
        if (resp !== graph_pkg::RESP_SLVERR)
            value_error($sformatf("unmapped write resp %b", resp));
        axi_read(4'h6, data, resp);
        if (data !== 32'h0 || resp !== graph_pkg::RESP_SLVERR)
            value_error($sformatf("unmapped read gave %h resp %b", data, resp));
        foreach (addrs[i])
            verify_register(addrs[i]);
        verify_register(graph_pkg::REG_CTRL);
    endtask

    task automatic curve_frames();
        graph_pkg::func_op_t ops [6];
        logic [3:0]          shifts [6];
        ops    = '{graph_pkg::FUNC_LINE, graph_pkg::FUNC_LINE, graph_pkg::FUNC_SQUARED,
                   graph_pkg::FUNC_SQUARED, graph_pkg::FUNC_CUBED, graph_pkg::FUNC_CUBED};
        shifts = '{4'd0, 4'd2, 4'd1, 4'd2, 4'd1, 4'd2};
        for (int i = 0; i < 6; i++) begin
            write_ctrl(ops[i], shifts[i], 1'b1);
            check_frame(shadow, $sformatf("%s shift %0d", ops[i].name(), shifts[i]));
        end
    endtask

    // New CTRL lands mid-frame while the frame in flight keeps the old curve
    task automatic midframe_update();
        graph_pkg::plot_cfg_t old_cfg;
        old_cfg = shadow;
        fork
            check_frame(old_cfg, "frame under update");
            begin
                wait_vsync(1'b1);
                repeat (11 * LINE_CYC) @(posedge clk_pix);  // About line 8 of output
                write_ctrl(graph_pkg::FUNC_SQUARED, 4'd0, 1'b1);
            end
        join
        check_frame(shadow, "frame after update");
    endtask

    initial begin
        rst_n         <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        shadow        = '0;
        shadow.op     = graph_pkg::FUNC_NONE;
        repeat (8) @(posedge clk_pix);
        rst_n <= 1'b1;
        check_reset_state();
        exercise_registers();
        write_ctrl(graph_pkg::FUNC_LINE, 4'd0, 1'b0);  // Axes and background only
        check_frame(shadow, "plot disabled");
        curve_frames();
        midframe_update();
        $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: graph_top.f
src/display_pkg.sv
src/graph_pkg.sv
src/display_timing.sv
src/graph_regs.sv
src/func_plot.sv
src/graph_painter.sv
src/graph_top.sv
bench/graph_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build graph_top_tb with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f graph_top.f \
    --top-module graph_top_tb -Mdir "$BUILD_DIR" -o graph_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/graph_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
